// ==== hw/ecc_pkg.sv ====
//------------------------------------------------------------
// SECDED code definitions shared by the encoder and checker.
// Holds the codeword widths, the field layout and the table
// that places each data bit at its Hamming position.
//------------------------------------------------------------
package ecc_pkg;

    // Payload, Hamming check and full codeword widths
    localparam int unsigned DATA_W = 32;
    localparam int unsigned CHK_W  = 6;
    localparam int unsigned CODE_W = 39;

    // Field layout inside the codeword
    localparam int unsigned CHK_LSB = DATA_W;
    localparam int unsigned PAR_BIT = CODE_W - 1;

    // Data bit i takes the (i+1)-th position in 1..38 that is not a power of two
    function automatic logic [DATA_W*CHK_W-1:0] build_hpos();
        logic [DATA_W*CHK_W-1:0] tbl;
        int unsigned n;
        tbl = '0;
        n = 0;
        for (int unsigned p = 1; p < CODE_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                tbl[n*CHK_W +: CHK_W] = CHK_W'(p);
                n++;
            end
        end
        return tbl;
    endfunction

    // Packed table, entry i sits in bits [i*CHK_W +: CHK_W]
    // Check bit k covers every data bit whose position has bit k set
    localparam logic [DATA_W*CHK_W-1:0] HPOS = build_hpos();

endpackage

// ==== hw/queue_pkg.sv ====
//------------------------------------------------------------
// Queue geometry and diagnostic injection layout.
// The top level takes its default parameters from here and
// the encoder uses the mask bit positions.
//------------------------------------------------------------
package queue_pkg;

    // Number of entries in the queue
    localparam int unsigned DEPTH = 16;

    // Pointer wide enough to address every entry
    localparam int unsigned PTR_W = 4;

    // Occupancy count needs one bit more to reach DEPTH
    localparam int unsigned CNT_W = 5;

    // Diagnostic mask, one bit per codeword bit that can be flipped
    localparam int unsigned INJ_W = 2;

    // Mask bit 0 hits the lowest data bit
    localparam int unsigned INJ_POS0 = 0;
    // Mask bit 1 hits the overall parity bit
    localparam int unsigned INJ_POS1 = 38;

endpackage

// ==== hw/rf_array_2p.sv ====
//------------------------------------------------------------
// Behavioral two-port storage array standing in for the
// register file macro. Write port on wclk, registered read
// port on rclk with an output reset.
//------------------------------------------------------------
`timescale 1ns/1ps

module rf_array_2p #(
    parameter int unsigned DEPTH  = 16,
    parameter int unsigned ADDR_W = 4,
    parameter int unsigned WIDTH  = 40
) (
    // Write port
    input  logic              wclk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [WIDTH-1:0]  wdata,

    // Read port
    input  logic              rclk,
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    input  logic              rst_sync,
    output logic [WIDTH-1:0]  rdata
);

    // Storage cells
    logic [WIDTH-1:0] mem [DEPTH];

    // Write happens at the edge where we is high
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // The read register holds its value between reads
    // and clears under the synchronized reset like the macro output stage
    always_ff @(posedge rclk) begin
        if (rst_sync) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hw/rf_16x39.sv ====
//------------------------------------------------------------
// Register file wrapper for the 16x39 codeword store.
// Pads writes to the 40-bit physical array, synchronizes the
// array reset on rclk and adds the output register stage.
//------------------------------------------------------------
`timescale 1ns/1ps

module rf_16x39 #(
    parameter int unsigned DEPTH  = 16,
    parameter int unsigned ADDR_W = 4,
    parameter int unsigned WIDTH  = 40
) (
    input  logic                        wclk,
    input  logic                        rclk,
    input  logic                        rst,

    input  logic                        we,
    input  logic [ADDR_W-1:0]           waddr,
    input  logic [ecc_pkg::CODE_W-1:0]  wdata,

    input  logic                        re,
    input  logic [ADDR_W-1:0]           raddr,
    output logic [ecc_pkg::CODE_W-1:0]  rdata
);

    import ecc_pkg::*;

    logic [1:0]        rst_sync_q;
    logic              rst_sync;
    logic [WIDTH-1:0]  arr_wdata;
    logic [WIDTH-1:0]  arr_rdata;

    //------------------------------------------------------------
    // Reset synchronizer
    //------------------------------------------------------------

    // Two flops on rclk, so release lags rst by two cycles
    always_ff @(posedge rclk) begin
        rst_sync_q <= {rst_sync_q[0], rst};
    end

    assign rst_sync = rst_sync_q[1];

    //------------------------------------------------------------
    // Array and data path
    //------------------------------------------------------------

    // The spare physical bit is written as zero
    assign arr_wdata = {{(WIDTH - CODE_W){1'b0}}, wdata};

    rf_array_2p #(
        .DEPTH  (DEPTH),
        .ADDR_W (ADDR_W),
        .WIDTH  (WIDTH)
    ) i_rf (
        .wclk     (wclk),
        .we       (we),
        .waddr    (waddr),
        .wdata    (arr_wdata),
        .rclk     (rclk),
        .re       (re),
        .raddr    (raddr),
        .rst_sync (rst_sync),
        .rdata    (arr_rdata)
    );

    // Second read stage, the spare bit is dropped here
    always_ff @(posedge rclk) begin
        rdata <= arr_rdata[CODE_W-1:0];
    end

endmodule

// ==== hw/ecc_secded_enc.sv ====
//------------------------------------------------------------
// Combinational SECDED encoder for the write path.
// Builds the Hamming checks and overall parity, then applies
// the diagnostic mask before the word goes to the array.
//------------------------------------------------------------
`timescale 1ns/1ps

module ecc_secded_enc (
    input  logic [ecc_pkg::DATA_W-1:0]  data,
    input  logic [queue_pkg::INJ_W-1:0] inject,
    output logic [ecc_pkg::CODE_W-1:0]  code
);

    import ecc_pkg::*;
    import queue_pkg::*;

    logic [CHK_W-1:0]  chk;
    logic [CODE_W-1:0] clean;

    // Each check bit is the XOR of the data bits whose position has that bit set
    always_comb begin
        chk = '0;
        for (int unsigned i = 0; i < DATA_W; i++) begin
            for (int unsigned k = 0; k < CHK_W; k++) begin
                if (HPOS[i*CHK_W + k]) begin
                    chk[k] = chk[k] ^ data[i];
                end
            end
        end
    end

    // Data and checks first, overall parity covers everything below it
    always_comb begin
        clean                   = '0;
        clean[DATA_W-1:0]       = data;
        clean[CHK_LSB +: CHK_W] = chk;
        clean[PAR_BIT]          = ^clean[PAR_BIT-1:0];
    end

    // Diagnostic flips are applied after parity so they show up as errors
    always_comb begin
        code           = clean;
        code[INJ_POS0] = clean[INJ_POS0] ^ inject[0];
        code[INJ_POS1] = clean[INJ_POS1] ^ inject[1];
    end

endmodule

// ==== hw/ecc_secded_dec.sv ====
//------------------------------------------------------------
// SECDED checker on the read path.
// Computes the syndrome and overall parity, corrects single
// errors, flags double errors and registers the result when
// the controller signals a pending read.
//------------------------------------------------------------
`timescale 1ns/1ps

module ecc_secded_dec (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_pending,
    input  logic [ecc_pkg::CODE_W-1:0]  code,
    output logic [ecc_pkg::DATA_W-1:0]  data,
    output logic                        valid,
    output logic                        sb_err,
    output logic                        db_err
);

    import ecc_pkg::*;

    logic [CHK_W-1:0]  syn;
    logic              par_odd;
    logic [DATA_W-1:0] fixed;
    logic              sb;
    logic              db;

    //------------------------------------------------------------
    // Syndrome and parity check
    //------------------------------------------------------------

    // Start from the stored checks and fold in the recomputed ones
    always_comb begin
        syn = code[CHK_LSB +: CHK_W];
        for (int unsigned i = 0; i < DATA_W; i++) begin
            for (int unsigned k = 0; k < CHK_W; k++) begin
                if (HPOS[i*CHK_W + k]) begin
                    syn[k] = syn[k] ^ code[i];
                end
            end
        end
    end

    // Parity over the whole codeword is odd after any single flip
    assign par_odd = ^code;

    //------------------------------------------------------------
    // Classification and correction
    //------------------------------------------------------------

    // Odd parity means one flipped bit somewhere in the codeword
    // A zero syndrome in that case points at the parity bit itself
    // Even parity with a nonzero syndrome is two flipped bits
    always_comb begin
        fixed = code[DATA_W-1:0];
        sb    = par_odd;
        db    = !par_odd && (syn != '0);
        if (par_odd && (syn != '0)) begin
            // Flip only when the syndrome names a data position
            for (int unsigned i = 0; i < DATA_W; i++) begin
                if (HPOS[i*CHK_W +: CHK_W] == syn) begin
                    fixed[i] = ~fixed[i];
                end
            end
        end
    end

    //------------------------------------------------------------
    // Output register
    //------------------------------------------------------------

    // The corrected word is loaded with each pending read
    always_ff @(posedge clk) begin
        if (rd_pending) begin
            data <= fixed;
        end
    end

    // valid is a one-cycle pulse per completed read
    always_ff @(posedge clk) begin
        if (rst) begin
            valid  <= 1'b0;
            sb_err <= 1'b0;
            db_err <= 1'b0;
        end else begin
            valid <= rd_pending;
            if (rd_pending) begin
                sb_err <= sb;
                db_err <= db;
            end
        end
    end

endmodule

// ==== hw/ecc_queue_ctrl.sv ====
//------------------------------------------------------------
// Queue controller. Applies the push and pop acceptance
// rules, keeps the pointers and count, and tracks reads in
// flight so the checker knows when its input is valid.
//------------------------------------------------------------
`timescale 1ns/1ps

module ecc_queue_ctrl #(
    parameter int unsigned DEPTH = 16,
    parameter int unsigned PTR_W = 4,
    parameter int unsigned CNT_W = 5
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,

    // Array write port
    output logic             we,
    output logic [PTR_W-1:0] waddr,

    // Array read port
    output logic             re,
    output logic [PTR_W-1:0] raddr,
    output logic             rd_pending,

    // Status
    output logic             full,
    output logic             empty,
    output logic [CNT_W-1:0] count,
    output logic             overflow
);

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] cnt;
    logic [1:0]       hold_q;
    logic             hold;
    logic             rd_q;
    logic             push_ok;
    logic             pop_ok;

    //------------------------------------------------------------
    // Acceptance
    //------------------------------------------------------------

    // Status comes straight from the count
    assign full  = (cnt == CNT_W'(DEPTH));
    assign empty = (cnt == '0);
    assign count = cnt;

    // The array reset stays asserted two cycles past rst, so requests wait too
    assign hold = |hold_q;

    // Both decisions use the status before this edge
    assign push_ok = push && !full && !hold;
    assign pop_ok  = pop && !empty && !hold;

    // The array sees the accepted strobes in the same cycle
    assign we    = push_ok;
    assign waddr = wptr;
    assign re    = pop_ok;
    assign raddr = rptr;

    //------------------------------------------------------------
    // Pointers, count and flags
    //------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr       <= '0;
            rptr       <= '0;
            cnt        <= '0;
            overflow   <= 1'b0;
            hold_q     <= 2'b11;
            rd_q       <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            hold_q <= {hold_q[0], 1'b0};

            // Pointers wrap at DEPTH
            if (push_ok) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (pop_ok) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end

            // Push and pop together leave the count unchanged
            case ({push_ok, pop_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase

            // A push into a full queue is lost and sticks until reset
            if (push && full) begin
                overflow <= 1'b1;
            end

            // Read pipeline, first stage matches the array read register,
            // second stage matches the wrapper output register
            rd_q       <= pop_ok;
            rd_pending <= rd_q;
        end
    end

endmodule

// ==== hw/ecc_queue_top.sv ====
//------------------------------------------------------------
// ECC queue top level. Wires the controller, the encoder,
// the 16x39 register file and the checker together. Both
// register file clocks run from clk.
//------------------------------------------------------------
`timescale 1ns/1ps

module ecc_queue_top #(
    parameter int unsigned DEPTH = queue_pkg::DEPTH,
    parameter int unsigned PTR_W = queue_pkg::PTR_W,
    parameter int unsigned CNT_W = queue_pkg::CNT_W,
    parameter int unsigned WIDTH = 40
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        push,
    input  logic [ecc_pkg::DATA_W-1:0]  push_data,
    input  logic [queue_pkg::INJ_W-1:0] inject,
    input  logic                        pop,

    output logic [ecc_pkg::DATA_W-1:0]  pop_data,
    output logic                        pop_valid,
    output logic                        sb_err,
    output logic                        db_err,

    output logic                        full,
    output logic                        empty,
    output logic [CNT_W-1:0]            count,
    output logic                        overflow
);

    import ecc_pkg::*;

    logic              we;
    logic [PTR_W-1:0]  waddr;
    logic              re;
    logic [PTR_W-1:0]  raddr;
    logic              rd_pending;
    logic [CODE_W-1:0] wdata;
    logic [CODE_W-1:0] rdata;

    ecc_queue_ctrl #(
        .DEPTH (DEPTH),
        .PTR_W (PTR_W),
        .CNT_W (CNT_W)
    ) i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .we         (we),
        .waddr      (waddr),
        .re         (re),
        .raddr      (raddr),
        .rd_pending (rd_pending),
        .full       (full),
        .empty      (empty),
        .count      (count),
        .overflow   (overflow)
    );

    // Write word is encoded in the same cycle as the push
    ecc_secded_enc i_enc (
        .data   (push_data),
        .inject (inject),
        .code   (wdata)
    );

    rf_16x39 #(
        .DEPTH  (DEPTH),
        .ADDR_W (PTR_W),
        .WIDTH  (WIDTH)
    ) i_rf (
        .wclk  (clk),
        .rclk  (clk),
        .rst   (rst),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .re    (re),
        .raddr (raddr),
        .rdata (rdata)
    );

    ecc_secded_dec i_dec (
        .clk        (clk),
        .rst        (rst),
        .rd_pending (rd_pending),
        .code       (rdata),
        .data       (pop_data),
        .valid      (pop_valid),
        .sb_err     (sb_err),
        .db_err     (db_err)
    );

endmodule

// ==== tb/ecc_queue_tb.sv ====
//------------------------------------------------------------
// Self-checking testbench for the ECC queue top level.
// A reference model predicts every pop result, a compare
// process checks each pop_valid against it, and a cycle
// counter stops a run that hangs.
//------------------------------------------------------------
`timescale 1ns/1ps

module ecc_queue_tb;

    import ecc_pkg::*;
    import queue_pkg::*;

    localparam int          MAX_CYCLES = 2000;
    localparam int          LATENCY    = 3;
    localparam logic [31:0] SEED       = 32'h28bc_a808;

    logic               clk;
    logic               rst;
    logic               push;
    logic [DATA_W-1:0]  push_data;
    logic [INJ_W-1:0]   inject;
    logic               pop;
    logic [DATA_W-1:0]  pop_data;
    logic               pop_valid;
    logic               sb_err;
    logic               db_err;
    logic               full;
    logic               empty;
    logic [CNT_W-1:0]   count;
    logic               overflow;

    // Reference model contents, oldest word at the front
    logic [DATA_W-1:0]  ref_data [$];
    logic [INJ_W-1:0]   ref_mask [$];
    int                 model_cnt;
    logic               model_ovf;

    // Predicted results as {db, sb, data} with the edge that accepted each pop
    logic [DATA_W+1:0]  exp_res [$];
    int                 exp_edge [$];

    int                 cyc;
    int                 pass_cnt;
    int                 fail_cnt;
    int                 test_fail_start;
    string              test_name;

    ecc_queue_top #(
        .DEPTH (DEPTH),
        .PTR_W (PTR_W),
        .CNT_W (CNT_W),
        .WIDTH (40)
    ) i_ecc_queue_top (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .inject    (inject),
        .pop       (pop),
        .pop_data  (pop_data),
        .pop_valid (pop_valid),
        .sb_err    (sb_err),
        .db_err    (db_err),
        .full      (full),
        .empty     (empty),
        .count     (count),
        .overflow  (overflow)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    //------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------

    // Expected {db, sb, data} for a stored word and its injection mask
    function automatic logic [DATA_W+1:0] expected_result(logic [DATA_W-1:0] d,
                                                          logic [INJ_W-1:0] m);
        logic [DATA_W-1:0] exp_d;
        logic              sb;
        logic              db;
        exp_d = d;
        sb    = 1'b0;
        db    = 1'b0;
        case (m)
            // One flipped bit is corrected, the word comes back intact
            2'd1, 2'd2: sb = 1'b1;
            // Two flips are only detected, so the flipped data bit stays flipped
            2'd3: begin
                db       = 1'b1;
                exp_d[0] = ~d[0];
            end
            default: ;
        endcase
        return {db, sb, exp_d};
    endfunction

    task automatic check_eq(string what, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) begin
            pass_cnt++;
        end else begin
            $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
            fail_cnt++;
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive(logic p, logic q, logic [DATA_W-1:0] d, logic [INJ_W-1:0] m);
        next_cycle();
        push      = p;
        pop       = q;
        push_data = d;
        inject    = m;
    endtask

    // Idle until every stored word has been read and checked
    task automatic wait_drain();
        drive(1'b0, 1'b0, '0, '0);
        while (ref_data.size() != 0 || exp_res.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) next_cycle();
    endtask

    task automatic end_test();
        $display("test %s done, %0d failed checks", test_name, fail_cnt - test_fail_start);
        test_fail_start = fail_cnt;
    endtask

    //------------------------------------------------------------
    // Cycle counter and timeout
    //------------------------------------------------------------

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    //------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------

    // Runs mid-cycle, where inputs and status are stable, and
    // predicts what the coming edge does
    always @(negedge clk) begin
        logic push_acc;
        logic pop_acc;
        if (rst) begin
            ref_data.delete();
            ref_mask.delete();
            model_cnt = 0;
            model_ovf = 1'b0;
        end else begin
            check_eq("count", 32'(model_cnt), 32'(count));
            check_eq("full", 32'(model_cnt == DEPTH), 32'(full));
            check_eq("empty", 32'(model_cnt == 0), 32'(empty));
            check_eq("overflow", 32'(model_ovf), 32'(overflow));

            // Both decisions use the occupancy before the edge
            push_acc = push && (model_cnt < DEPTH);
            pop_acc  = pop && (model_cnt > 0);
            if (pop_acc) begin
                exp_res.push_back(expected_result(ref_data.pop_front(), ref_mask.pop_front()));
                exp_edge.push_back(cyc + 1);
            end
            if (push_acc) begin
                ref_data.push_back(push_data);
                ref_mask.push_back(inject);
            end
            if (push && !push_acc) begin
                model_ovf = 1'b1;
            end
            model_cnt = model_cnt + int'(push_acc) - int'(pop_acc);
        end
    end

    //------------------------------------------------------------
    // Compare process
    //------------------------------------------------------------

    always @(negedge clk) begin
        logic [DATA_W+1:0] res;
        int                edge_no;
        if (!rst && pop_valid) begin
            assert (exp_res.size() != 0) else begin
                $display("Unexpected pop result in test %s, no pop was pending", test_name);
                fail_cnt++;
            end
            if (exp_res.size() != 0) begin
                res     = exp_res.pop_front();
                edge_no = exp_edge.pop_front();
                check_eq("pop_data", res[DATA_W-1:0], pop_data);
                check_eq("sb_err", 32'(res[DATA_W]), 32'(sb_err));
                check_eq("db_err", 32'(res[DATA_W+1]), 32'(db_err));
                // The next rising edge is the one that sees pop_valid
                check_eq("latency", 32'(LATENCY), 32'(cyc + 1 - edge_no));
            end
        end
    end

    //------------------------------------------------------------
    // Tests
    //------------------------------------------------------------

    initial begin
        logic [31:0] r;
        int          pushed;
        int          popped;
        logic        do_push;
        logic        do_pop;
        clk             = 1'b0;
        rst             = 1'b1;
        push            = 1'b0;
        pop             = 1'b0;
        push_data       = '0;
        inject          = '0;
        cyc             = 0;
        model_cnt       = 0;
        model_ovf       = 1'b0;
        pass_cnt        = 0;
        fail_cnt        = 0;
        test_fail_start = 0;
        test_name       = "reset_state";
        void'($urandom(SEED));

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // Array reset release and controller hold take two more cycles
        repeat (4) next_cycle();
        check_eq("empty", 32'd1, 32'(empty));
        check_eq("full", 32'd0, 32'(full));
        check_eq("overflow", 32'd0, 32'(overflow));
        check_eq("count", 32'd0, 32'(count));
        check_eq("pop_valid", 32'd0, 32'(pop_valid));
        repeat (8) next_cycle();
        end_test();

        // Random interleaving of pushes, pops and idle cycles
        test_name = "ordered_data";
        pushed    = 0;
        popped    = 0;
        while (popped < 40) begin
            next_cycle();
            r       = $urandom;
            do_push = (pushed < 40) && r[0] && (model_cnt < DEPTH);
            do_pop  = r[1] && (model_cnt > 0);
            if (r[3:2] == 2'b00) begin
                do_push = 1'b0;
                do_pop  = 1'b0;
            end
            push      = do_push;
            pop       = do_pop;
            push_data = $urandom;
            inject    = '0;
            pushed    = pushed + int'(do_push);
            popped    = popped + int'(do_pop);
        end
        wait_drain();
        end_test();

        test_name = "full_overflow";
        for (int i = 0; i < DEPTH; i++) begin
            drive(1'b1, 1'b0, $urandom, '0);
        end
        // The 17th push is driven once all 16 have landed
        drive(1'b1, 1'b0, $urandom, '0);
        check_eq("full", 32'd1, 32'(full));
        check_eq("count", 32'(DEPTH), 32'(count));
        drive(1'b0, 1'b0, '0, '0);
        check_eq("overflow", 32'd1, 32'(overflow));
        for (int i = 0; i < DEPTH; i++) begin
            drive(1'b0, 1'b1, '0, '0);
        end
        wait_drain();
        end_test();

        test_name = "empty_pop";
        repeat (3) drive(1'b0, 1'b1, '0, '0);
        // Push and pop on an empty queue, only the push counts
        drive(1'b1, 1'b1, $urandom, '0);
        drive(1'b0, 1'b1, '0, '0);
        drive(1'b0, 1'b1, '0, '0);
        wait_drain();
        check_eq("count", 32'd0, 32'(count));
        end_test();

        test_name = "single_error";
        for (int i = 0; i < 6; i++) begin
            drive(1'b1, 1'b0, $urandom, (i % 2 == 0) ? 2'd1 : 2'd2);
        end
        repeat (6) drive(1'b0, 1'b1, '0, '0);
        wait_drain();
        end_test();

        // Double errors alternate with clean words
        test_name = "double_error";
        for (int i = 0; i < 6; i++) begin
            drive(1'b1, 1'b0, $urandom, (i % 2 == 0) ? 2'd3 : 2'd0);
        end
        repeat (6) drive(1'b0, 1'b1, '0, '0);
        wait_drain();
        end_test();

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/ecc_pkg.sv
hw/queue_pkg.sv
hw/rf_array_2p.sv
hw/rf_16x39.sv
hw/ecc_secded_enc.sv
hw/ecc_secded_dec.sv
hw/ecc_queue_ctrl.sv
hw/ecc_queue_top.sv
tb/ecc_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the ECC queue testbench with Verilator and runs it.
# Exits nonzero unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module ecc_queue_tb -o ecc_queue_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/ecc_queue_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
